// ==== pci_bus_sys.f ====
hdl/pci_pkg.sv
hdl/pci_arbiter.sv
hdl/pci_initiator.sv
hdl/pci_target.sv
hdl/pci_bus_sys.sv
dv/pci_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the PCI bus system testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=pci_bus_tb_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module pci_bus_tb -f pci_bus_sys.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== dv/pci_bus_tb.sv ====
// ==========================================================================
// PCI bus system testbench
// write/read bursts, arbitration priority, host back-pressure, index wrap
// and master abort, checked against a reference memory model
// ==========================================================================
`timescale 1ns/1ps

module pci_bus_tb;
    import pci_pkg::*;

    localparam int NUM_DEV     = 2;
    localparam int MEM_WORDS   = 16;
    localparam int TOTAL_WORDS = 88;                        // words moved over all tests
    localparam int WD_CYCLES   = TOTAL_WORDS * 20 + 300;    // reset and idle margin
    localparam int WAIT_LIMIT  = 200;                       // cycles for one handshake

    logic                              clk         = 1'b0;
    logic                              arst_n      = 1'b0;
    logic                [NUM_DEV-1:0] cmd_valid   = '0;
    logic                [NUM_DEV-1:0] cmd_write   = '0;
    dev_id_t             [NUM_DEV-1:0] cmd_id      = '0;
    word_idx_t           [NUM_DEV-1:0] cmd_word    = '0;
    burst_len_t          [NUM_DEV-1:0] cmd_len     = '0;
    logic                [NUM_DEV-1:0] wr_valid    = '0;
    data_t               [NUM_DEV-1:0] wr_data     = '0;
    logic                [NUM_DEV-1:0] rd_ready    = '1;
    logic                [NUM_DEV-1:0] cmd_ready;
    logic                [NUM_DEV-1:0] wr_ready;
    logic                [NUM_DEV-1:0] rd_valid;
    data_t               [NUM_DEV-1:0] rd_data;
    logic                [NUM_DEV-1:0] done;
    logic                [NUM_DEV-1:0] done_err;

    data_t ref_mem [1:NUM_DEV][MEM_WORDS];  // expected target memories, by id
    data_t exp_rd  [NUM_DEV][256];          // expected read words, in order
    logic  exp_st  [NUM_DEV][64];           // expected done_err per burst
    data_t wr_buf  [NUM_DEV][8];
    int    rd_head [NUM_DEV];
    int    rd_tail [NUM_DEV];
    int    st_head [NUM_DEV];
    int    st_tail [NUM_DEV];
    int    done_cnt [NUM_DEV];
    time   done_time [NUM_DEV];
    logic  [NUM_DEV-1:0] rd_stall_en = '0;
    logic  [NUM_DEV-1:0] wr_stall_en = '0;
    logic  [15:0] rd_lfsr = 16'd26;
    logic  [15:0] wr_lfsr = 16'd26;
    int    errors = 0;
    int    test_errs0 = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    burst_tag = 0;
    string cur_test = "reset";

    always #2 clk = ~clk;               // 4 ns period

    pci_bus_sys #(
        .NUM_DEV   (NUM_DEV),
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_write (cmd_write),
        .cmd_id    (cmd_id),
        .cmd_word  (cmd_word),
        .cmd_len   (cmd_len),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_data   (wr_data),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_data   (rd_data),
        .done      (done),
        .done_err  (done_err)
    );

    // fibonacci, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // word a read of this id and index must return
    function automatic data_t exp_read_word(input int id, input int idx);
        return ref_mem[id][idx % MEM_WORDS];    // target index wraps
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_word(input string what, input data_t exp, input data_t act);
        if (act !== exp)
        begin
            $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input int d, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("mismatch %s dev%0d done_err: expected %0b actual %0b",
                     cur_test, d, exp, act);
            errors++;
        end
    endtask

    // host side of every device: read sink and done collector
    always @(negedge clk)
    begin
        for (int d = 0; d < NUM_DEV; d++)
        begin
            rd_ready[d] = 1'b1;
            if (rd_stall_en[d])
            begin
                rd_ready[d] = rd_lfsr[0];           // one bit per cycle
                rd_lfsr     = lfsr_step(rd_lfsr);
            end
            if (rd_valid[d] && rd_ready[d])         // taken on the next rising edge
            begin
                if (rd_head[d] == rd_tail[d])
                    report_error($sformatf("device %0d returned a read word nobody asked for",
                                           d));
                else
                begin
                    check_word($sformatf("dev%0d word %0d", d, rd_head[d]),
                               exp_rd[d][rd_head[d]], rd_data[d]);
                    rd_head[d]++;
                end
            end
            if (done[d])
            begin
                if (st_head[d] == st_tail[d])
                    report_error($sformatf("device %0d pulsed done without a command", d));
                else
                begin
                    check_status(d, exp_st[d][st_head[d]], done_err[d]);
                    st_head[d]++;
                end
                done_cnt[d]++;
                done_time[d] = $time;
            end
        end
    end

    task automatic send_cmd(input int d, input logic write, input dev_id_t id,
                            input word_idx_t word, input burst_len_t len);
        int waited;
        waited = 0;
        @(negedge clk);
        cmd_valid[d] = 1'b1;
        cmd_write[d] = write;
        cmd_id[d]    = id;
        cmd_word[d]  = word;
        cmd_len[d]   = len;
        while (!cmd_ready[d] && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ready[d])
            report_error($sformatf("device %0d never accepted its command", d));
        @(negedge clk);                             // handshake edge has passed
        cmd_valid[d] = 1'b0;
    endtask

    task automatic drive_writes(input int d, input int n);
        int   k;
        int   waited;
        logic stall;
        k      = 0;
        waited = 0;
        while (k < n && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            stall = 1'b0;
            if (wr_stall_en[d])
            begin
                stall   = wr_lfsr[0];
                wr_lfsr = lfsr_step(wr_lfsr);
            end
            wr_valid[d] = !stall;                   // gap, not tied to wr_ready
            wr_data[d]  = wr_buf[d][k];
            if (wr_valid[d] && wr_ready[d])
                k++;
            waited++;
        end
        if (k < n)
            report_error($sformatf("device %0d took only %0d of %0d write words", d, k, n));
        @(negedge clk);
        wr_valid[d] = 1'b0;
    endtask

    task automatic wait_done(input int d, input int start);
        int waited;
        waited = 0;
        while (done_cnt[d] == start && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (done_cnt[d] == start)
            report_error($sformatf("device %0d gave no done within %0d cycles", d, WAIT_LIMIT));
    endtask

    task automatic wait_reads(input int d);
        int waited;
        waited = 0;
        while (rd_head[d] != rd_tail[d] && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rd_head[d] != rd_tail[d])
            report_error($sformatf("device %0d is missing %0d read words", d,
                                   rd_tail[d] - rd_head[d]));
    endtask

    // one burst from device d, expectations queued before the command
    task automatic run_burst(input int d, input logic write, input int id,
                             input int word, input int len);
        int   start;
        int   k;
        logic exp_err;
        start   = done_cnt[d];
        exp_err = (id < 1) || (id > NUM_DEV);       // no target claims it
        burst_tag++;
        for (k = 0; k <= len; k++)
        begin
            if (write)
            begin
                wr_buf[d][k] = {8'(burst_tag), 8'(id), 8'(word + k), 8'hA5 ^ 8'(k)};
                if (!exp_err)
                    ref_mem[id][(word + k) % MEM_WORDS] = wr_buf[d][k];
            end
            else if (!exp_err)
            begin
                exp_rd[d][rd_tail[d]] = exp_read_word(id, word + k);
                rd_tail[d]++;
            end
        end
        exp_st[d][st_tail[d]] = exp_err;
        st_tail[d]++;
        send_cmd(d, write, dev_id_t'(id), word_idx_t'(word), burst_len_t'(len));
        if (write && !exp_err)
            drive_writes(d, len + 1);
        wait_done(d, start);
        wait_reads(d);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs0 = errors;
    endtask

    task automatic end_test();
        if (errors == test_errs0)
        begin
            n_pass++;
            $display("test %s: ok", cur_test);
        end
        else
        begin
            n_fail++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_errs0);
        end
    endtask

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", WD_CYCLES, cur_test);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("write_read");
        run_burst(0, 1'b1, 2, 0, 7);                // dev0 -> id 2, 8 words
        run_burst(0, 1'b0, 2, 0, 7);
        end_test();

        start_test("priority");
        fork
            run_burst(0, 1'b1, 2, 8, 3);
            run_burst(1, 1'b1, 1, 0, 3);
        join
        if (done_time[1] >= done_time[0])
            report_error("device 1 did not finish ahead of device 0");
        run_burst(1, 1'b0, 1, 0, 3);
        run_burst(0, 1'b0, 2, 8, 3);
        end_test();

        start_test("read_backpressure");
        rd_stall_en[0] = 1'b1;
        run_burst(0, 1'b0, 2, 0, 7);
        rd_stall_en[0] = 1'b0;
        end_test();

        start_test("write_stalls");
        wr_stall_en[1] = 1'b1;
        run_burst(1, 1'b1, 1, 4, 5);
        wr_stall_en[1] = 1'b0;
        run_burst(1, 1'b0, 1, 4, 5);
        end_test();

        start_test("wraparound");
        run_burst(0, 1'b1, 2, MEM_WORDS - 2, 3);    // 14, 15, 0, 1
        run_burst(0, 1'b0, 2, MEM_WORDS - 2, 3);
        run_burst(0, 1'b0, 2, 0, 7);
        end_test();

        start_test("master_abort");
        run_burst(0, 1'b0, 7, 0, 1);
        run_burst(1, 1'b1, 7, 0, 1);                // write abort, no data offered
        run_burst(0, 1'b0, 2, 0, 7);
        run_burst(1, 1'b0, 1, 0, 7);
        end_test();

        repeat (4) @(negedge clk);
        $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/pci_bus_sys.sv ====
// ==========================================================================
// PCI-style shared bus system
// arbiter plus one initiator and one target per device; strobes are
// ANDed and AD/cbe shares ORed into the shared bus
// ==========================================================================
`timescale 1ns/1ps

module pci_bus_sys #(
    parameter int NUM_DEV   = 2,
    parameter int MEM_WORDS = 16
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [NUM_DEV-1:0]                   cmd_valid,
    output logic [NUM_DEV-1:0]                   cmd_ready,
    input  logic [NUM_DEV-1:0]                   cmd_write,
    input  pci_pkg::dev_id_t    [NUM_DEV-1:0]    cmd_id,
    input  pci_pkg::word_idx_t  [NUM_DEV-1:0]    cmd_word,
    input  pci_pkg::burst_len_t [NUM_DEV-1:0]    cmd_len,
    input  logic [NUM_DEV-1:0]                   wr_valid,
    output logic [NUM_DEV-1:0]                   wr_ready,
    input  pci_pkg::data_t      [NUM_DEV-1:0]    wr_data,
    output logic [NUM_DEV-1:0]                   rd_valid,
    input  logic [NUM_DEV-1:0]                   rd_ready,
    output pci_pkg::data_t      [NUM_DEV-1:0]    rd_data,
    output logic [NUM_DEV-1:0]                   done,
    output logic [NUM_DEV-1:0]                   done_err
);
    import pci_pkg::*;

    logic [NUM_DEV-1:0]      req_n;
    logic [NUM_DEV-1:0]      gnt_n;
    logic [NUM_DEV-1:0]      frame_drv_n;
    logic [NUM_DEV-1:0]      irdy_drv_n;
    logic [NUM_DEV-1:0]      devsel_drv_n;
    logic [NUM_DEV-1:0]      trdy_drv_n;
    data_t [NUM_DEV-1:0]     ad_init;       // initiator AD shares
    data_t [NUM_DEV-1:0]     ad_tgt;        // target AD shares
    logic [NUM_DEV-1:0][3:0] cbe_drv;
    logic                    frame_n;
    logic                    irdy_n;
    logic                    devsel_n;
    logic                    trdy_n;
    data_t                   ad;
    logic [3:0]              cbe;

    // wired-AND of the active-low strobes
    assign frame_n  = &frame_drv_n;
    assign irdy_n   = &irdy_drv_n;
    assign devsel_n = &devsel_drv_n;
    assign trdy_n   = &trdy_drv_n;

    // idle drivers put zero on AD/cbe, so OR gives the active one
    always_comb
    begin
        ad  = '0;
        cbe = '0;
        for (int d = 0; d < NUM_DEV; d++)
        begin
            ad  = ad | ad_init[d] | ad_tgt[d];
            cbe = cbe | cbe_drv[d];
        end
    end

    pci_arbiter #(
        .NUM_DEV (NUM_DEV)
    ) arb_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_n   (req_n),
        .frame_n (frame_n),
        .irdy_n  (irdy_n),
        .gnt_n   (gnt_n)
    );

    for (genvar d = 0; d < NUM_DEV; d++)
    begin : g_dev
        pci_initiator #(
            .DEV_ID (d + 1)             // id 0 is never a device
        ) init_i (
            .clk         (clk),
            .arst_n      (arst_n),
            .cmd_valid   (cmd_valid[d]),
            .cmd_write   (cmd_write[d]),
            .cmd_id      (cmd_id[d]),
            .cmd_word    (cmd_word[d]),
            .cmd_len     (cmd_len[d]),
            .wr_valid    (wr_valid[d]),
            .wr_data     (wr_data[d]),
            .rd_ready    (rd_ready[d]),
            .gnt_n       (gnt_n[d]),
            .frame_n     (frame_n),
            .irdy_n      (irdy_n),
            .devsel_n    (devsel_n),
            .trdy_n      (trdy_n),
            .ad          (ad),
            .cmd_ready   (cmd_ready[d]),
            .wr_ready    (wr_ready[d]),
            .rd_valid    (rd_valid[d]),
            .rd_data     (rd_data[d]),
            .done        (done[d]),
            .done_err    (done_err[d]),
            .req_n       (req_n[d]),
            .frame_drv_n (frame_drv_n[d]),
            .irdy_drv_n  (irdy_drv_n[d]),
            .ad_drv      (ad_init[d]),
            .cbe_drv     (cbe_drv[d])
        );

        pci_target #(
            .DEV_ID    (d + 1),
            .MEM_WORDS (MEM_WORDS)
        ) tgt_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .frame_n      (frame_n),
            .irdy_n       (irdy_n),
            .cbe          (cbe),
            .ad           (ad),
            .devsel_drv_n (devsel_drv_n[d]),
            .trdy_drv_n   (trdy_drv_n[d]),
            .ad_drv       (ad_tgt[d])
        );
    end

endmodule

// ==== hdl/pci_target.sv ====
// ==========================================================================
// PCI bus target
// claims address phases carrying its own id, then writes AD into its word
// memory or drives memory words, index wrapping; turnaround after a burst
// ==========================================================================
`timescale 1ns/1ps

module pci_target #(
    parameter int DEV_ID    = 1,
    parameter int MEM_WORDS = 16
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           frame_n,
    input  logic           irdy_n,
    input  logic [3:0]     cbe,
    input  pci_pkg::data_t ad,
    output logic           devsel_drv_n,
    output logic           trdy_drv_n,
    output pci_pkg::data_t ad_drv
);
    import pci_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    tgt_state_e       state;
    bus_cmd_e         cmd_q;
    logic [IDX_W-1:0] idx_q;            // current word index
    logic             idle_q;           // bus was idle last cycle
    logic             addr_hit;
    logic             xfer;
    word_idx_t        start_word;
    data_t            mem [MEM_WORDS];

    assign start_word = ad[AD_WORD_LSB +: WORD_W];
    // frame falling after an idle cycle, id match
    assign addr_hit = (state == T_IDLE) && idle_q && !frame_n
                      && (ad[AD_ID_LSB +: ID_W] == dev_id_t'(DEV_ID));
    assign xfer     = (state == T_DATA) && !irdy_n;   // own trdy is low in T_DATA

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= T_IDLE;
            idle_q <= 1'b1;
        end
        else
        begin
            idle_q <= frame_n & irdy_n;
            case (state)
                T_IDLE: if (addr_hit) state <= T_DATA;
                T_DATA: if (xfer && frame_n) state <= T_TURN;   // last data phase
                T_TURN: state <= T_IDLE;
                default: state <= T_IDLE;
            endcase
        end
    end

    // latched command, index and memory
    always_ff @(posedge clk)
    begin
        if (addr_hit)
        begin
            cmd_q <= bus_cmd_e'(cbe);
            idx_q <= IDX_W'(start_word % MEM_WORDS);
        end
        else if (xfer)
            idx_q <= (idx_q == IDX_W'(MEM_WORDS - 1)) ? '0 : idx_q + 1'b1;   // wrap
        if (xfer && (cmd_q == CMD_WRITE))
            mem[idx_q] <= ad;
    end

    assign devsel_drv_n = (state != T_DATA);
    assign trdy_drv_n   = (state != T_DATA);     // no wait states on the target side
    assign ad_drv       = ((state == T_DATA) && (cmd_q == CMD_READ)) ? mem[idx_q] : '0;

    // initiator must not leave the bus idle while this target is claimed
    a_no_idle_claim : assert property (@(posedge clk) disable iff (!arst_n)
        (state == T_DATA) |-> !(frame_n && irdy_n))
        else $error("target %0d saw an idle bus mid-burst", DEV_ID);

endmodule

// ==== hdl/pci_initiator.sv ====
// ==========================================================================
// PCI bus initiator
// accepts a burst command, requests the bus, drives the address phase and
// one word per data phase; one-entry read register, devsel timeout abort
// ==========================================================================
`timescale 1ns/1ps

module pci_initiator #(
    parameter int DEV_ID = 1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  logic                cmd_write,
    input  pci_pkg::dev_id_t    cmd_id,
    input  pci_pkg::word_idx_t  cmd_word,
    input  pci_pkg::burst_len_t cmd_len,
    input  logic                wr_valid,
    input  pci_pkg::data_t      wr_data,
    input  logic                rd_ready,
    input  logic                gnt_n,
    input  logic                frame_n,
    input  logic                irdy_n,
    input  logic                devsel_n,
    input  logic                trdy_n,
    input  pci_pkg::data_t      ad,
    output logic                cmd_ready,
    output logic                wr_ready,
    output logic                rd_valid,
    output pci_pkg::data_t      rd_data,
    output logic                done,
    output logic                done_err,
    output logic                req_n,
    output logic                frame_drv_n,
    output logic                irdy_drv_n,
    output pci_pkg::data_t      ad_drv,
    output logic [3:0]          cbe_drv
);
    import pci_pkg::*;

    localparam int TO_W = $clog2(DEVSEL_TIMEOUT);

    init_state_e     state;
    init_state_e     state_nxt;
    bus_cmd_e        cmd_q;
    dev_id_t         id_q;
    word_idx_t       word_q;
    burst_len_t      remain_q;          // words left minus one
    logic [TO_W-1:0] to_cnt;
    logic            abort_q;
    logic            accept;
    logic            bus_idle;
    logic            host_rdy;
    logic            xfer;
    logic            last;
    logic            timeout;

    assign accept   = cmd_valid && cmd_ready;
    assign bus_idle = frame_n & irdy_n;
    // write needs a word from the host, read needs room in the register
    assign host_rdy = (cmd_q == CMD_WRITE) ? wr_valid : (!rd_valid || rd_ready);
    assign xfer     = (state == I_DATA) && !irdy_drv_n && !trdy_n;
    assign last     = (remain_q == '0);
    // last cycle of the devsel window, nobody claimed
    assign timeout  = (state == I_DATA) && devsel_n
                      && (to_cnt == TO_W'(DEVSEL_TIMEOUT - 2));

    always_comb
    begin
        state_nxt = state;
        case (state)
            I_IDLE: if (accept) state_nxt = I_REQ;
            I_REQ:  if (!gnt_n && bus_idle) state_nxt = I_ADDR;
            I_ADDR: state_nxt = I_DATA;         // single address cycle
            I_DATA: if ((xfer && last) || timeout) state_nxt = I_DONE;
            I_DONE: state_nxt = I_IDLE;
            default: state_nxt = I_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= I_IDLE;
            cmd_ready <= 1'b0;
            remain_q  <= '0;
            to_cnt    <= '0;
            abort_q   <= 1'b0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            cmd_ready <= (state_nxt == I_IDLE);   // held low out of reset
            if (accept)
                remain_q <= cmd_len;
            else if (xfer)
                remain_q <= remain_q - 1'b1;
            if (state == I_ADDR)
                to_cnt <= '0;                     // window opens after address
            else if ((state == I_DATA) && devsel_n)
                to_cnt <= to_cnt + 1'b1;
            if (accept)
                abort_q <= 1'b0;
            else if (timeout)
                abort_q <= 1'b1;                  // master abort, reported on done
            if (xfer && (cmd_q == CMD_READ))
                rd_valid <= 1'b1;
            else if (rd_ready)
                rd_valid <= 1'b0;
        end
    end

    // command and read word payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_q  <= cmd_write ? CMD_WRITE : CMD_READ;
            id_q   <= cmd_id;
            word_q <= cmd_word;
        end
        if (xfer && (cmd_q == CMD_READ))
            rd_data <= ad;
    end

    assign req_n      = !((state == I_REQ) || (state == I_ADDR) || (state == I_DATA));
    assign irdy_drv_n = !((state == I_DATA) && host_rdy);
    // frame rises only together with irdy in the last phase, bus never looks idle
    assign frame_drv_n = !((state == I_ADDR)
                           || ((state == I_DATA) && (!last || irdy_drv_n)));
    assign wr_ready   = (state == I_DATA) && (cmd_q == CMD_WRITE) && !trdy_n;
    assign done       = (state == I_DONE);
    assign done_err   = (state == I_DONE) && abort_q;

    always_comb
    begin
        ad_drv  = '0;                   // idle share, ORed at the top
        cbe_drv = '0;
        if (state == I_ADDR)
        begin
            ad_drv[AD_ID_LSB +: ID_W]     = id_q;
            ad_drv[AD_WORD_LSB +: WORD_W] = word_q;
            cbe_drv                       = cmd_q;
        end
        else if ((state == I_DATA) && (cmd_q == CMD_WRITE))
            ad_drv = wr_data;
    end

    a_no_self : assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> (cmd_id != dev_id_t'(DEV_ID)))
        else $error("device %0d addressed itself", DEV_ID);

    // address phase decided on a cycle where the grant was ours
    a_frame_gnt : assert property (@(posedge clk) disable iff (!arst_n)
        $fell(frame_drv_n) |-> $past(!gnt_n))
        else $error("device %0d drove frame without grant", DEV_ID);

endmodule

// ==== hdl/pci_arbiter.sv ====
// ==========================================================================
// PCI bus arbiter
// fixed priority, highest device index wins; registered one-hot active-low
// grant which only moves while the bus is idle
// ==========================================================================
`timescale 1ns/1ps

module pci_arbiter #(
    parameter int NUM_DEV = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [NUM_DEV-1:0] req_n,
    input  logic               frame_n,
    input  logic               irdy_n,
    output logic [NUM_DEV-1:0] gnt_n
);

    logic               bus_idle;
    logic [NUM_DEV-1:0] gnt_nxt_n;

    assign bus_idle = frame_n & irdy_n;     // no address or data phase

    // later (higher) index overrides lower ones
    always_comb
    begin
        gnt_nxt_n = '1;
        for (int i = 0; i < NUM_DEV; i++)
        begin
            if (!req_n[i])
            begin
                gnt_nxt_n    = '1;
                gnt_nxt_n[i] = 1'b0;
            end
        end
    end

    // owner keeps the grant through its burst
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            gnt_n <= '1;                    // nobody granted
        else if (bus_idle)
            gnt_n <= gnt_nxt_n;
    end

    a_gnt_onehot : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(~gnt_n))
        else $error("more than one gnt_n low: %b", gnt_n);

endmodule

// ==== hdl/pci_pkg.sv ====
// ==========================================================================
// PCI-style shared bus definitions
// word and field widths, AD layout of the address phase, bus commands,
// initiator and target FSM encodings
// ==========================================================================
package pci_pkg;

    localparam int DATA_W = 32;     // AD width
    localparam int ID_W   = 8;      // target id field
    localparam int WORD_W = 8;      // start word field
    localparam int LEN_W  = 3;      // burst length, 1..8 words

    // address phase layout on AD
    localparam int AD_WORD_LSB = 0;     // start word index in AD[7:0]
    localparam int AD_ID_LSB   = 8;     // target id in AD[15:8]

    // cycles after the address phase with no devsel before master abort
    localparam int DEVSEL_TIMEOUT = 3;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   dev_id_t;
    typedef logic [WORD_W-1:0] word_idx_t;
    typedef logic [LEN_W-1:0]  burst_len_t;    // word count minus one

    // command code on cbe during the address phase
    typedef enum logic [3:0] {
        CMD_READ  = 4'b0000,
        CMD_WRITE = 4'b1000
    } bus_cmd_e;

    typedef enum logic [2:0] {
        I_IDLE,     // waiting for a host command
        I_REQ,      // req_n low, waiting for grant and idle bus
        I_ADDR,     // one address phase cycle
        I_DATA,     // data phases until last word or abort
        I_DONE      // completion pulse
    } init_state_e;

    typedef enum logic [1:0] {
        T_IDLE,     // snooping for address phases
        T_DATA,     // claimed, devsel/trdy low
        T_TURN      // one turnaround cycle
    } tgt_state_e;

endpackage
